// ==== motor_pkg.sv ====
`default_nettype none

package motor_pkg;

	// bus word sizes
	localparam int WB_DATA_W = 32;

	// uart character and frame layout, 8N1
	localparam int UART_DATA_W = 8;
	localparam int UART_FRAME_BITS = 10;

	// fixed bit rate in clocks per serial bit
	localparam int TICKS_PER_BAUD = 4;

	// first sample lands in the middle of the start bit
	localparam int UART_MID_TICK = TICKS_PER_BAUD / 2 - 1;

	// counter widths for the serial engines
	localparam int UART_TICK_W = $clog2(TICKS_PER_BAUD);
	localparam int UART_BIT_W = $clog2(UART_FRAME_BITS);

	// pwm period is 2**PWM_CNT_W clocks
	localparam int PWM_CNT_W = 8;

	// duty loaded by the setup master, 48 high clocks per period
	localparam logic [PWM_CNT_W-1:0] PWM_INIT_DUTY = 8'h30;

	// bus master FSM encoding, shared by both masters
	localparam int BUS_ST_W = 2;
	localparam logic [BUS_ST_W-1:0] BUS_IDLE = 2'd0;
	localparam logic [BUS_ST_W-1:0] BUS_REQUEST = 2'd1;
	localparam logic [BUS_ST_W-1:0] BUS_WAIT_ACK = 2'd2;
	localparam logic [BUS_ST_W-1:0] BUS_END = 2'd3;

endpackage

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
	input  logic                              clock,
	input  logic                              rst_n_i,
	input  logic                              rx_i,
	output logic [motor_pkg::UART_DATA_W-1:0] rx_data_o,
	output logic                              rx_valid_o
);
	import motor_pkg::*;

	logic                   rx_meta;
	logic                   rx_sync;
	logic                   rx_prev;
	logic                   active;
	logic                   sample;
	logic [UART_TICK_W-1:0] tick_cnt;
	logic [UART_BIT_W-1:0]  bit_cnt;
	logic [UART_DATA_W-1:0] shift_q;

	// two flop synchroniser, third flop for edge detect
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign sample = active && (tick_cnt == '0);

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			active <= 1'b0;
			tick_cnt <= '0;
			bit_cnt <= '0;
			rx_valid_o <= 1'b0;
		end else begin
			rx_valid_o <= 1'b0;
			if (!active) begin
				// falling edge starts a frame
				if (rx_prev && !rx_sync) begin
					active <= 1'b1;
					tick_cnt <= UART_TICK_W'(UART_MID_TICK);
					bit_cnt <= '0;
				end
			end else if (tick_cnt != '0) begin
				tick_cnt <= tick_cnt - UART_TICK_W'(1);
			end else begin
				tick_cnt <= UART_TICK_W'(TICKS_PER_BAUD - 1);
				bit_cnt <= bit_cnt + UART_BIT_W'(1);
				if (bit_cnt == '0 && rx_sync) begin
					// start bit gone high again, just a glitch
					active <= 1'b0;
				end else if (bit_cnt == UART_BIT_W'(UART_FRAME_BITS - 1)) begin
					// low stop bit drops the frame
					active <= 1'b0;
					rx_valid_o <= rx_sync;
				end
			end
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge clock) begin
		if (sample && bit_cnt != '0 && bit_cnt != UART_BIT_W'(UART_FRAME_BITS - 1)) begin
			shift_q <= {rx_sync, shift_q[UART_DATA_W-1:1]};
		end
	end

	assign rx_data_o = shift_q;

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
	input  logic                              clock,
	input  logic                              rst_n_i,
	input  logic [motor_pkg::UART_DATA_W-1:0] tx_data_i,
	input  logic                              tx_start_i,
	output logic                              tx_o,
	output logic                              busy_o
);
	import motor_pkg::*;

	logic [UART_FRAME_BITS-1:0] frame_q;
	logic [UART_TICK_W-1:0]     tick_cnt;
	logic [UART_BIT_W-1:0]      bits_left;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			// all ones keeps the line idle
			frame_q <= '1;
			tick_cnt <= '0;
			bits_left <= '0;
			busy_o <= 1'b0;
		end else if (!busy_o) begin
			if (tx_start_i) begin
				// stop bit, data lsb first, start bit
				frame_q <= {1'b1, tx_data_i, 1'b0};
				tick_cnt <= UART_TICK_W'(TICKS_PER_BAUD - 1);
				bits_left <= UART_BIT_W'(UART_FRAME_BITS - 1);
				busy_o <= 1'b1;
			end
		end else if (tick_cnt != '0) begin
			tick_cnt <= tick_cnt - UART_TICK_W'(1);
		end else if (bits_left == '0) begin
			// stop bit fully sent, line rests on it
			busy_o <= 1'b0;
		end else begin
			frame_q <= {1'b1, frame_q[UART_FRAME_BITS-1:1]};
			tick_cnt <= UART_TICK_W'(TICKS_PER_BAUD - 1);
			bits_left <= bits_left - UART_BIT_W'(1);
		end
	end

	assign tx_o = frame_q[0];

endmodule

`default_nettype wire

// ==== wb_uart.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_uart (
	input  logic                            clock,
	input  logic                            rst_n_i,
	input  logic                            wb_stb_i,
	input  logic                            wb_cyc_i,
	input  logic                            wb_we_i,
	input  logic                            wb_adr_i,
	input  logic [motor_pkg::WB_DATA_W-1:0] wb_dat_i,
	output logic [motor_pkg::WB_DATA_W-1:0] wb_dat_o,
	output logic                            wb_stall_o,
	output logic                            wb_ack_o,
	output logic                            rx_pending_o,
	output logic                            uart_tx_o,
	input  logic                            uart_rx_i
);
	import motor_pkg::*;

	logic [UART_DATA_W-1:0] rx_data;
	logic                   rx_valid;
	logic [UART_DATA_W-1:0] rx_byte;
	logic                   tx_busy;
	logic                   tx_start;
	logic                   accept;
	logic                   reg_hit;
	logic                   rd_accept;

	uart_rx u_rx (
		.clock      (clock),
		.rst_n_i    (rst_n_i),
		.rx_i       (uart_rx_i),
		.rx_data_o  (rx_data),
		.rx_valid_o (rx_valid)
	);

	uart_tx u_tx (
		.clock      (clock),
		.rst_n_i    (rst_n_i),
		.tx_data_i  (wb_dat_i[UART_DATA_W-1:0]),
		.tx_start_i (tx_start),
		.tx_o       (uart_tx_o),
		.busy_o     (tx_busy)
	);

	// single register at address zero
	assign reg_hit = (wb_adr_i == 1'b0);

	// only writes wait for the transmitter
	assign wb_stall_o = wb_we_i && tx_busy;
	assign accept = wb_cyc_i && wb_stb_i && !wb_stall_o;
	assign rd_accept = accept && !wb_we_i;
	assign tx_start = accept && wb_we_i && reg_hit;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_ack_o <= 1'b0;
			rx_pending_o <= 1'b0;
		end else begin
			wb_ack_o <= accept;
			// a new byte wins over a read in the same cycle
			if (rx_valid) begin
				rx_pending_o <= 1'b1;
			end else if (rd_accept && reg_hit) begin
				rx_pending_o <= 1'b0;
			end
		end
	end

	// unread byte is simply overwritten
	always_ff @(posedge clock) begin
		if (rx_valid) begin
			rx_byte <= rx_data;
		end
		if (rd_accept) begin
			wb_dat_o <= reg_hit ? {{(WB_DATA_W - UART_DATA_W){1'b0}}, rx_byte} : '0;
		end
	end

endmodule

`default_nettype wire

// ==== wb_pwm.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_pwm (
	input  logic                            clock,
	input  logic                            rst_n_i,
	input  logic                            wb_stb_i,
	input  logic                            wb_cyc_i,
	input  logic                            wb_we_i,
	input  logic                            wb_adr_i,
	input  logic [motor_pkg::WB_DATA_W-1:0] wb_dat_i,
	output logic [motor_pkg::WB_DATA_W-1:0] wb_dat_o,
	output logic                            wb_stall_o,
	output logic                            wb_ack_o,
	output logic                            pwm_o
);
	import motor_pkg::*;

	logic [PWM_CNT_W-1:0] cnt_q;
	logic [PWM_CNT_W-1:0] duty_pend;
	logic [PWM_CNT_W-1:0] duty_act;
	logic                 accept;
	logic                 reg_hit;
	logic                 wrap;

	// register updates never need to wait
	assign wb_stall_o = 1'b0;
	assign accept = wb_cyc_i && wb_stb_i;
	assign reg_hit = (wb_adr_i == 1'b0);
	assign wrap = (cnt_q == '1);

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
			duty_pend <= '0;
			duty_act <= '0;
			wb_ack_o <= 1'b0;
			pwm_o <= 1'b0;
		end else begin
			cnt_q <= cnt_q + PWM_CNT_W'(1);
			wb_ack_o <= accept;
			if (accept && wb_we_i && reg_hit) begin
				duty_pend <= wb_dat_i[PWM_CNT_W-1:0];
			end
			// new duty only at period boundary, no runt pulses
			if (wrap) begin
				duty_act <= duty_pend;
			end
			pwm_o <= (cnt_q < duty_act);
		end
	end

	// read back the pending duty
	always_ff @(posedge clock) begin
		if (accept && !wb_we_i) begin
			wb_dat_o <= reg_hit ? {{(WB_DATA_W - PWM_CNT_W){1'b0}}, duty_pend} : '0;
		end
	end

endmodule

`default_nettype wire

// ==== motor_ctrl_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module motor_ctrl_top (
	input  logic clock,
	input  logic rst_n_i,
	input  logic uart_rx_i,
	output logic uart_tx_o,
	output logic pwm_motor_o
);
	import motor_pkg::*;

	// echo master
	logic [BUS_ST_W-1:0]  echo_state;
	logic                 echo_write;
	logic [WB_DATA_W-1:0] echo_buf;
	logic                 uart_stb;
	logic                 uart_cyc;
	logic [WB_DATA_W-1:0] uart_rdata;
	logic                 uart_stall;
	logic                 uart_ack;
	logic                 rx_pending;

	// pwm setup master
	logic [BUS_ST_W-1:0]  pwm_state;
	logic                 pwm_stb;
	logic                 pwm_cyc;
	logic                 pwm_stall;
	logic                 pwm_ack;

	// alternate read then write, so every received byte goes back out
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			echo_state <= BUS_IDLE;
			echo_write <= 1'b0;
		end else begin
			case (echo_state)
				BUS_IDLE: begin
					// writes go at once, reads wait for a byte
					if (echo_write || rx_pending) begin
						echo_state <= BUS_REQUEST;
					end
				end
				BUS_REQUEST: begin
					if (!uart_stall) begin
						echo_state <= BUS_WAIT_ACK;
					end
				end
				BUS_WAIT_ACK: begin
					if (uart_ack) begin
						echo_state <= BUS_END;
					end
				end
				BUS_END: begin
					echo_write <= !echo_write;
					echo_state <= BUS_IDLE;
				end
				default: begin
					echo_state <= BUS_IDLE;
				end
			endcase
		end
	end

	// keep the received byte for the write back
	always_ff @(posedge clock) begin
		if (echo_state == BUS_WAIT_ACK && uart_ack && !echo_write) begin
			echo_buf <= uart_rdata;
		end
	end

	assign uart_stb = (echo_state == BUS_REQUEST);
	assign uart_cyc = (echo_state == BUS_REQUEST) || (echo_state == BUS_WAIT_ACK);

	wb_uart u_uart (
		.clock        (clock),
		.rst_n_i      (rst_n_i),
		.wb_stb_i     (uart_stb),
		.wb_cyc_i     (uart_cyc),
		.wb_we_i      (echo_write),
		.wb_adr_i     (1'b0),
		.wb_dat_i     (echo_buf),
		.wb_dat_o     (uart_rdata),
		.wb_stall_o   (uart_stall),
		.wb_ack_o     (uart_ack),
		.rx_pending_o (rx_pending),
		.uart_tx_o    (uart_tx_o),
		.uart_rx_i    (uart_rx_i)
	);

	// one duty write after reset, then park in BUS_END
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pwm_state <= BUS_IDLE;
		end else begin
			case (pwm_state)
				BUS_IDLE: begin
					pwm_state <= BUS_REQUEST;
				end
				BUS_REQUEST: begin
					if (!pwm_stall) begin
						pwm_state <= BUS_WAIT_ACK;
					end
				end
				BUS_WAIT_ACK: begin
					if (pwm_ack) begin
						pwm_state <= BUS_END;
					end
				end
				default: begin
					pwm_state <= BUS_END;
				end
			endcase
		end
	end

	assign pwm_stb = (pwm_state == BUS_REQUEST);
	assign pwm_cyc = (pwm_state == BUS_REQUEST) || (pwm_state == BUS_WAIT_ACK);

	wb_pwm u_pwm (
		.clock      (clock),
		.rst_n_i    (rst_n_i),
		.wb_stb_i   (pwm_stb),
		.wb_cyc_i   (pwm_cyc),
		.wb_we_i    (1'b1),
		.wb_adr_i   (1'b0),
		.wb_dat_i   ({{(WB_DATA_W - PWM_CNT_W){1'b0}}, PWM_INIT_DUTY}),
		.wb_dat_o   (),
		.wb_stall_o (pwm_stall),
		.wb_ack_o   (pwm_ack),
		.pwm_o      (pwm_motor_o)
	);

endmodule

`default_nettype wire

// ==== motor_ctrl_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_bus_sva (
	input logic clock,
	input logic rst_n_i,
	input logic stb_i,
	input logic cyc_i,
	input logic we_i,
	input logic stall_i,
	input logic ack_i,
	input logic tx_i,
	input logic tx_busy_i
);

	logic accepted;
	int   err_cnt = 0;

	assign accepted = cyc_i && stb_i && !stall_i;

	// ack exactly one cycle after acceptance, never otherwise
	a_ack_follows: assert property (@(posedge clock) disable iff (!rst_n_i)
		accepted |=> ack_i) else begin
		err_cnt++;
		$error("ack missing one cycle after accepted request");
	end

	a_no_stray_ack: assert property (@(posedge clock) disable iff (!rst_n_i)
		!accepted |=> !ack_i) else begin
		err_cnt++;
		$error("ack without an accepted request");
	end

	a_stb_in_cyc: assert property (@(posedge clock) disable iff (!rst_n_i)
		stb_i |-> cyc_i) else begin
		err_cnt++;
		$error("stb raised outside a bus cycle");
	end

	// reads are never held off
	a_read_no_stall: assert property (@(posedge clock) disable iff (!rst_n_i)
		(cyc_i && stb_i && !we_i) |-> !stall_i) else begin
		err_cnt++;
		$error("stall raised on a read");
	end

	a_line_idle: assert property (@(posedge clock) disable iff (!rst_n_i)
		!tx_busy_i |-> tx_i) else begin
		err_cnt++;
		$error("serial line low while transmitter idle");
	end

endmodule

bind wb_uart uart_bus_sva u_bus_sva (
	.clock     (clock),
	.rst_n_i   (rst_n_i),
	.stb_i     (wb_stb_i),
	.cyc_i     (wb_cyc_i),
	.we_i      (wb_we_i),
	.stall_i   (wb_stall_o),
	.ack_i     (wb_ack_o),
	.tx_i      (uart_tx_o),
	.tx_busy_i (tx_busy)
);

`default_nettype wire

// ==== tb_motor_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_motor_ctrl;
	import motor_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam logic [31:0] RAND_SEED = 32'hf4caad33;
	localparam int FRAME_CYC = TICKS_PER_BAUD * 10;
	localparam int PWM_PERIOD = 256;
	// duty 8'h30 gives 48 high clocks per period
	localparam int EXP_PWM_HIGH = 48;
	localparam int FRAMES_SENT = 1 + 5 + 16 + 2;
	// pwm settle plus measurement span
	localparam int PWM_WINDOW_CYC = 1024;
	localparam int WATCHDOG_NS = 2 * (FRAMES_SENT * 2 * FRAME_CYC * CLK_PERIOD
		+ 2 * PWM_WINDOW_CYC * CLK_PERIOD);

	logic clock;
	logic rst_n_i;
	logic uart_rx_i;
	logic uart_tx_o;
	logic pwm_motor_o;

	logic [UART_DATA_W-1:0] exp_q[$];
	logic [UART_DATA_W-1:0] got_q[$];

	motor_ctrl_top u_dut (
		.clock       (clock),
		.rst_n_i     (rst_n_i),
		.uart_rx_i   (uart_rx_i),
		.uart_tx_o   (uart_tx_o),
		.pwm_motor_o (pwm_motor_o)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping at first failure");
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else stop_with_failure($sformatf(
			"[ERROR] %0t ns %s expected %0h actual %0h", $time, name, expected, actual));
	endtask

	// n cycles on, landing just after the rising edge
	task automatic step(input int n);
		repeat (n) begin
			@(posedge clock);
			#0.5;
		end
	endtask

	task automatic idle_cycles(input int n);
		uart_rx_i = 1'b1;
		step(n);
	endtask

	task automatic drive_bit(input logic b);
		uart_rx_i = b;
		step(TICKS_PER_BAUD);
	endtask

	// 8N1, lsb first; stop bit may be forced low
	task automatic send_frame(input logic [UART_DATA_W-1:0] data, input logic stop_bit);
		drive_bit(1'b0);
		for (int i = 0; i < UART_DATA_W; i++) begin
			drive_bit(data[i]);
		end
		drive_bit(stop_bit);
	endtask

	task automatic receive_frame(output logic [UART_DATA_W-1:0] data);
		data = '0;
		do @(negedge clock); while (uart_tx_o !== 1'b0);
		// move to the middle of the start bit
		repeat (TICKS_PER_BAUD / 2 - 1) @(negedge clock);
		assert (uart_tx_o === 1'b0) else stop_with_failure(
			"start bit on uart_tx_o ended before its middle");
		for (int i = 0; i < UART_DATA_W; i++) begin
			repeat (TICKS_PER_BAUD) @(negedge clock);
			data[i] = uart_tx_o;
		end
		repeat (TICKS_PER_BAUD) @(negedge clock);
		assert (uart_tx_o === 1'b1) else stop_with_failure($sformatf(
			"[ERROR] %0t ns uart_tx_o stop bit expected 1 actual %b", $time, uart_tx_o));
	endtask

	// waits for all expected echoes, then for a quiet line
	task automatic expect_echo(input int limit_cycles);
		int waited;
		waited = 0;
		while (got_q.size() < exp_q.size() && waited < limit_cycles) begin
			step(1);
			waited++;
		end
		assert (got_q.size() >= exp_q.size()) else stop_with_failure($sformatf(
			"timeout waiting for echo, %0d of %0d frames seen on uart_tx_o",
			got_q.size(), exp_q.size()));
		step(2 * FRAME_CYC);
		compare_value("echo frame count", exp_q.size(), got_q.size());
		foreach (exp_q[i]) begin
			compare_value($sformatf("uart_tx_o byte %0d", i), exp_q[i], got_q[i]);
		end
		exp_q.delete();
		got_q.delete();
	endtask

	task automatic reset_levels();
		repeat (RESET_CYCLES / 2) @(posedge clock);
		#0.5;
		compare_value("uart_tx_o in reset", 1, uart_tx_o);
		compare_value("pwm_motor_o in reset", 0, pwm_motor_o);
		repeat (RESET_CYCLES - RESET_CYCLES / 2) @(posedge clock);
		#0.5;
		rst_n_i = 1'b1;
		step(2);
		compare_value("uart_tx_o after reset", 1, uart_tx_o);
		compare_value("pwm_motor_o after reset", 0, pwm_motor_o);
	endtask

	task automatic pwm_duty();
		int high_cnt;
		int pulse_len;
		int guard;
		high_cnt = 0;
		step(600);
		repeat (PWM_PERIOD) begin
			@(negedge clock);
			if (pwm_motor_o === 1'b1) begin
				high_cnt++;
			end
		end
		compare_value("pwm_motor_o high cycles per period", EXP_PWM_HIGH, high_cnt);
		for (int p = 0; p < 2; p++) begin
			guard = 0;
			@(negedge clock);
			while (pwm_motor_o !== 1'b0 && guard < 2 * PWM_PERIOD) begin
				@(negedge clock);
				guard++;
			end
			while (pwm_motor_o !== 1'b1 && guard < 2 * PWM_PERIOD) begin
				@(negedge clock);
				guard++;
			end
			assert (pwm_motor_o === 1'b1) else stop_with_failure(
				"no rising edge on pwm_motor_o within two PWM periods");
			pulse_len = 0;
			while (pwm_motor_o === 1'b1 && pulse_len <= PWM_PERIOD) begin
				pulse_len++;
				@(negedge clock);
			end
			compare_value("pwm_motor_o pulse length", EXP_PWM_HIGH, pulse_len);
		end
	endtask

	task automatic single_byte_echo();
		idle_cycles(4);
		exp_q.push_back(8'hA5);
		send_frame(8'hA5, 1'b1);
		// three frame times counted from the start bit
		expect_echo(2 * FRAME_CYC);
	endtask

	task automatic burst_echo();
		logic [UART_DATA_W-1:0] burst [5];
		burst = '{8'h3C, 8'h00, 8'hFF, 8'h81, 8'h5A};
		idle_cycles(4);
		foreach (burst[i]) begin
			exp_q.push_back(burst[i]);
			send_frame(burst[i], 1'b1);
		end
		expect_echo(3 * FRAME_CYC);
	endtask

	task automatic random_byte_echo();
		logic [UART_DATA_W-1:0] data;
		int gap;
		idle_cycles(4);
		for (int n = 0; n < 16; n++) begin
			data = UART_DATA_W'($urandom);
			gap = $urandom % 21;
			exp_q.push_back(data);
			send_frame(data, 1'b1);
			idle_cycles(gap);
		end
		expect_echo(3 * FRAME_CYC);
	endtask

	task automatic framing_error_drop();
		idle_cycles(4);
		send_frame(8'h66, 1'b0);
		// line must go high again before the next start bit
		idle_cycles(2 * TICKS_PER_BAUD);
		exp_q.push_back(8'h42);
		send_frame(8'h42, 1'b1);
		expect_echo(2 * FRAME_CYC);
	endtask

	// collects every frame seen on the serial output
	initial begin
		logic [UART_DATA_W-1:0] rx_byte;
		wait (rst_n_i === 1'b1);
		forever begin
			receive_frame(rx_byte);
			got_q.push_back(rx_byte);
		end
	end

	// protocol checker bound inside the UART slave
	initial begin
		wait (u_dut.u_uart.u_bus_sva.err_cnt != 0);
		stop_with_failure("bus protocol assertion failed on the UART slave");
	end

	initial begin
		#(WATCHDOG_NS);
		stop_with_failure($sformatf("timeout, run did not finish within %0d ns", WATCHDOG_NS));
	end

	initial begin
		clock = 1'b0;
		rst_n_i = 1'b0;
		uart_rx_i = 1'b1;
		void'($urandom(RAND_SEED));
		reset_levels();
		pwm_duty();
		single_byte_echo();
		burst_echo();
		random_byte_echo();
		framing_error_drop();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
motor_pkg.sv
uart_rx.sv
uart_tx.sv
wb_uart.sv
wb_pwm.sv
motor_ctrl_top.sv
motor_ctrl_sva.sv
tb_motor_ctrl.sv

// ==== Bender.yml ====
package:
  name: motor_ctrl

sources:
  - files:
      - motor_pkg.sv
      - uart_rx.sv
      - uart_tx.sv
      - wb_uart.sv
      - wb_pwm.sv
      - motor_ctrl_top.sv
  - target: test
    files:
      - motor_ctrl_sva.sv
      - tb_motor_ctrl.sv
